// ==== verilog/isa_pkg.sv ====
package isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] inst_addr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [3:0]  mask_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    // OP_NOP must stay zero so that an all-zero payload is a bubble
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADDU = 4'd1,
        OP_SUBU = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_SLT  = 4'd5,
        OP_ORI  = 4'd6,
        OP_LUI  = 4'd7,
        OP_LW   = 4'd8,
        OP_SW   = 4'd9,
        OP_SB   = 4'd10,
        OP_BEQ  = 4'd11,
        OP_BNE  = 4'd12
    } oper_t;

    // major opcodes, bits 31:26
    localparam opcode_t OPC_SPECIAL = 6'h00;
    localparam opcode_t OPC_BEQ     = 6'h04;
    localparam opcode_t OPC_BNE     = 6'h05;
    localparam opcode_t OPC_ADDIU   = 6'h09;
    localparam opcode_t OPC_ORI     = 6'h0d;
    localparam opcode_t OPC_LUI     = 6'h0f;
    localparam opcode_t OPC_LW      = 6'h23;
    localparam opcode_t OPC_SB      = 6'h28;
    localparam opcode_t OPC_SW      = 6'h2b;

    // function field of SPECIAL, bits 5:0
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_SLT  = 6'h2a;

endpackage

// ==== verilog/pipe_pkg.sv ====
package pipe_pkg;

    import isa_pkg::*;

    // fetched instruction and its address
    typedef struct packed {
        inst_addr_t pc;
        word_t      inst;
    } if_id_t;

    typedef struct packed {
        oper_t      oper;
        word_t      op_a;
        word_t      op_b;
        word_t      st_data;
        logic       dest_we;
        reg_addr_t  dest_addr;
    } id_ex_t;

    // result doubles as the effective address of loads and stores
    typedef struct packed {
        oper_t      oper;
        word_t      result;
        word_t      st_data;
        logic       dest_we;
        reg_addr_t  dest_addr;
    } ex_mem_t;

    typedef struct packed {
        logic       we;
        reg_addr_t  addr;
        word_t      data;
    } wb_t;

    // is_load marks data that is not ready yet
    typedef struct packed {
        logic       we;
        reg_addr_t  addr;
        word_t      data;
        logic       is_load;
    } fwd_t;

endpackage

// ==== verilog/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     hold_i,
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // zero payload decodes as a nop with writes disabled
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (bubble_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import isa_pkg::*, pipe_pkg::*; #(
    parameter inst_addr_t RESET_PC = '0
) (
    input  logic       clk,
    input  logic       arst_n_i,
    input  logic       stall_i,
    input  logic       branch_i,
    input  inst_addr_t branch_target_i,
    input  word_t      rom_data_i,
    output inst_addr_t rom_addr_o,
    output logic       rom_ce_o,
    output if_id_t     if_id_o
);

    inst_addr_t pc_q;
    logic       ce_q;

    // rom enable comes up one edge after reset release
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ce_q <= 1'b0;
        end else begin
            ce_q <= 1'b1;
        end
    end

    // stall wins over a branch, the branch is seen again next cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else if (!ce_q) begin
            pc_q <= RESET_PC;
        end else if (!stall_i) begin
            pc_q <= branch_i ? branch_target_i : pc_q + 32'd4;
        end
    end

    assign rom_addr_o = pc_q;
    assign rom_ce_o   = ce_q;

    // if/id register, bubbles until the rom is enabled
    stage_reg #(.payload_t(if_id_t)) i_if_id_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (stall_i),
        .bubble_i (!ce_q),
        .d_i      ('{pc: pc_q, inst: rom_data_i}),
        .q_o      (if_id_o)
    );

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile import isa_pkg::*, pipe_pkg::*; (
    input  logic      clk,
    input  logic      arst_n_i,
    input  wb_t       wb_i,
    input  reg_addr_t raddr_a_i,
    input  reg_addr_t raddr_b_i,
    output word_t     rdata_a_o,
    output word_t     rdata_b_o
);

    // r0 has no storage
    word_t regs_q [1:31];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_i.we && wb_i.addr != '0) begin
            regs_q[wb_i.addr] <= wb_i.data;
        end
    end

    // write-through so decode sees the value retiring this cycle
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wb_i.we && wb_i.addr == addr) begin
            return wb_i.data;
        end
        return regs_q[addr];
    endfunction

    always_comb begin
        rdata_a_o = read_port(raddr_a_i);
        rdata_b_o = read_port(raddr_b_i);
    end

endmodule

// ==== verilog/decode_unit.sv ====
`timescale 1ns/1ps

module decode_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic       clk,
    input  logic       arst_n_i,
    input  if_id_t     if_id_i,
    input  wb_t        wb_i,
    input  fwd_t       ex_fwd_i,
    input  fwd_t       mem_fwd_i,
    output id_ex_t     id_ex_o,
    output logic       branch_o,
    output inst_addr_t branch_target_o,
    output logic       stall_o
);

    opcode_t     opcode;
    funct_t      funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm;
    word_t       imm_sext;
    word_t       rf_a;
    word_t       rf_b;
    word_t       rs_val;
    word_t       rt_val;
    oper_t       oper;
    logic        use_rs;
    logic        use_rt;
    logic        wr_en;

    assign opcode   = if_id_i.inst[31:26];
    assign rs       = if_id_i.inst[25:21];
    assign rt       = if_id_i.inst[20:16];
    assign rd       = if_id_i.inst[15:11];
    assign funct    = if_id_i.inst[5:0];
    assign imm      = if_id_i.inst[15:0];
    assign imm_sext = {{16{imm[15]}}, imm};

    regfile i_regfile (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .wb_i      (wb_i),
        .raddr_a_i (rs),
        .raddr_b_i (rt),
        .rdata_a_o (rf_a),
        .rdata_b_o (rf_b)
    );

    always_comb begin
        case (opcode)
            OPC_SPECIAL: begin
                case (funct)
                    FN_ADDU: oper = OP_ADDU;
                    FN_SUBU: oper = OP_SUBU;
                    FN_AND:  oper = OP_AND;
                    FN_OR:   oper = OP_OR;
                    FN_SLT:  oper = OP_SLT;
                    default: oper = OP_NOP;
                endcase
            end
            // addiu shares the adder with addu
            OPC_ADDIU: oper = OP_ADDU;
            OPC_ORI:   oper = OP_ORI;
            OPC_LUI:   oper = OP_LUI;
            OPC_LW:    oper = OP_LW;
            OPC_SW:    oper = OP_SW;
            OPC_SB:    oper = OP_SB;
            OPC_BEQ:   oper = OP_BEQ;
            OPC_BNE:   oper = OP_BNE;
            default:   oper = OP_NOP;
        endcase
    end

    assign use_rs = !(oper inside {OP_NOP, OP_LUI});
    assign use_rt = (opcode == OPC_SPECIAL && oper != OP_NOP) ||
                    (oper inside {OP_SW, OP_SB, OP_BEQ, OP_BNE});
    assign wr_en  = !(oper inside {OP_NOP, OP_SW, OP_SB, OP_BEQ, OP_BNE});

    function automatic logic fwd_hit(fwd_t f, reg_addr_t src);
        return f.we && f.addr != '0 && f.addr == src;
    endfunction

    // execute first, then memory, then the register file
    assign rs_val = fwd_hit(ex_fwd_i, rs)  ? ex_fwd_i.data  :
                    fwd_hit(mem_fwd_i, rs) ? mem_fwd_i.data : rf_a;
    assign rt_val = fwd_hit(ex_fwd_i, rt)  ? ex_fwd_i.data  :
                    fwd_hit(mem_fwd_i, rt) ? mem_fwd_i.data : rf_b;

    // load data is not ready in execute, wait one cycle
    assign stall_o = ex_fwd_i.is_load &&
                     ((use_rs && fwd_hit(ex_fwd_i, rs)) || (use_rt && fwd_hit(ex_fwd_i, rt)));

    always_comb begin
        id_ex_o.oper      = oper;
        id_ex_o.op_a      = rs_val;
        id_ex_o.st_data   = rt_val;
        id_ex_o.dest_we   = wr_en;
        id_ex_o.dest_addr = (opcode == OPC_SPECIAL) ? rd : rt;
        case (opcode)
            OPC_SPECIAL, OPC_BEQ, OPC_BNE: id_ex_o.op_b = rt_val;
            OPC_ORI: id_ex_o.op_b = {16'h0000, imm};
            OPC_LUI: id_ex_o.op_b = {imm, 16'h0000};
            default: id_ex_o.op_b = imm_sext;
        endcase
    end

    // target is relative to the delay slot
    assign branch_o = (oper == OP_BEQ && rs_val == rt_val) ||
                      (oper == OP_BNE && rs_val != rt_val);
    assign branch_target_o = if_id_i.pc + 32'd4 + {imm_sext[29:0], 2'b00};

endmodule

// ==== verilog/execute_unit.sv ====
`timescale 1ns/1ps

module execute_unit import isa_pkg::*, pipe_pkg::*; (
    input  id_ex_t  id_ex_i,
    output ex_mem_t ex_mem_o,
    output fwd_t    ex_fwd_o
);

    word_t a;
    word_t b;
    word_t result;

    assign a = id_ex_i.op_a;
    assign b = id_ex_i.op_b;

    always_comb begin
        case (id_ex_i.oper)
            // memory ops use the adder for the effective address
            OP_ADDU, OP_LW, OP_SW, OP_SB: result = a + b;
            OP_SUBU:       result = a - b;
            OP_AND:        result = a & b;
            OP_OR, OP_ORI: result = a | b;
            OP_SLT:        result = {31'd0, $signed(a) < $signed(b)};
            // upper half already placed by decode
            OP_LUI:        result = b;
            default:       result = '0;
        endcase
    end

    always_comb begin
        ex_mem_o.oper      = id_ex_i.oper;
        ex_mem_o.result    = result;
        ex_mem_o.st_data   = id_ex_i.st_data;
        ex_mem_o.dest_we   = id_ex_i.dest_we;
        ex_mem_o.dest_addr = id_ex_i.dest_addr;
    end

    // a load here only reports its address, decode stalls on a match
    always_comb begin
        ex_fwd_o.we      = id_ex_i.dest_we;
        ex_fwd_o.addr    = id_ex_i.dest_addr;
        ex_fwd_o.data    = result;
        ex_fwd_o.is_load = (id_ex_i.oper == OP_LW);
    end

endmodule

// ==== verilog/mem_unit.sv ====
`timescale 1ns/1ps

module mem_unit import isa_pkg::*, pipe_pkg::*; (
    input  ex_mem_t ex_mem_i,
    input  word_t   ram_data_i,
    output word_t   ram_addr_o,
    output word_t   ram_data_o,
    output logic    ram_we_o,
    output logic    ram_re_o,
    output mask_t   ram_mask_o,
    output wb_t     wb_o,
    output fwd_t    mem_fwd_o
);

    logic [1:0] lane;
    word_t      wb_data;

    assign lane       = ex_mem_i.result[1:0];
    assign ram_addr_o = {ex_mem_i.result[31:2], 2'b00};

    always_comb begin
        ram_we_o   = 1'b0;
        ram_re_o   = 1'b0;
        ram_mask_o = '0;
        ram_data_o = ex_mem_i.st_data;
        case (ex_mem_i.oper)
            OP_SW: begin
                ram_we_o   = 1'b1;
                ram_mask_o = 4'b1111;
            end
            OP_SB: begin
                // little-endian lane, byte copied to every lane
                ram_we_o   = 1'b1;
                ram_mask_o = 4'b0001 << lane;
                ram_data_o = {4{ex_mem_i.st_data[7:0]}};
            end
            OP_LW: ram_re_o = 1'b1;
            default: ;
        endcase
    end

    assign wb_data = ram_re_o ? ram_data_i : ex_mem_i.result;

    assign wb_o = '{we: ex_mem_i.dest_we, addr: ex_mem_i.dest_addr, data: wb_data};

    assign mem_fwd_o = '{we: ex_mem_i.dest_we, addr: ex_mem_i.dest_addr,
                         data: wb_data, is_load: ram_re_o};

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps

module cpu import isa_pkg::*, pipe_pkg::*; #(
    parameter inst_addr_t RESET_PC = '0
) (
    input  logic       clk,
    input  logic       arst_n_i,
    input  word_t      rom_data_i,
    output inst_addr_t rom_addr_o,
    output logic       rom_ce_o,
    input  word_t      ram_data_i,
    output word_t      ram_addr_o,
    output word_t      ram_data_o,
    output logic       ram_re_o,
    output logic       ram_we_o,
    output mask_t      ram_mask_o
);

    if_id_t     if_id;
    id_ex_t     id_ex_d;
    id_ex_t     id_ex_q;
    ex_mem_t    ex_mem_d;
    ex_mem_t    ex_mem_q;
    wb_t        wb_d;
    wb_t        wb_q;
    fwd_t       ex_fwd;
    fwd_t       mem_fwd;
    logic       stall;
    logic       branch;
    inst_addr_t branch_target;

    fetch_unit #(.RESET_PC(RESET_PC)) i_fetch (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .stall_i         (stall),
        .branch_i        (branch),
        .branch_target_i (branch_target),
        .rom_data_i      (rom_data_i),
        .rom_addr_o      (rom_addr_o),
        .rom_ce_o        (rom_ce_o),
        .if_id_o         (if_id)
    );

    decode_unit i_decode (
        .clk             (clk),
        .arst_n_i        (arst_n_i),
        .if_id_i         (if_id),
        .wb_i            (wb_q),
        .ex_fwd_i        (ex_fwd),
        .mem_fwd_i       (mem_fwd),
        .id_ex_o         (id_ex_d),
        .branch_o        (branch),
        .branch_target_o (branch_target),
        .stall_o         (stall)
    );

    // a stall turns the instruction entering execute into a bubble
    stage_reg #(.payload_t(id_ex_t)) i_id_ex_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .bubble_i (stall),
        .d_i      (id_ex_d),
        .q_o      (id_ex_q)
    );

    execute_unit i_execute (
        .id_ex_i  (id_ex_q),
        .ex_mem_o (ex_mem_d),
        .ex_fwd_o (ex_fwd)
    );

    stage_reg #(.payload_t(ex_mem_t)) i_ex_mem_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .bubble_i (1'b0),
        .d_i      (ex_mem_d),
        .q_o      (ex_mem_q)
    );

    mem_unit i_mem (
        .ex_mem_i   (ex_mem_q),
        .ram_data_i (ram_data_i),
        .ram_addr_o (ram_addr_o),
        .ram_data_o (ram_data_o),
        .ram_we_o   (ram_we_o),
        .ram_re_o   (ram_re_o),
        .ram_mask_o (ram_mask_o),
        .wb_o       (wb_d),
        .mem_fwd_o  (mem_fwd)
    );

    // mem/wb output is the register file write port
    stage_reg #(.payload_t(wb_t)) i_mem_wb_reg (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .bubble_i (1'b0),
        .d_i      (wb_d),
        .q_o      (wb_q)
    );

endmodule

// ==== tests/tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model import isa_pkg::*; (
    input  logic       clk,
    input  inst_addr_t rom_addr_i,
    input  logic       rom_ce_i,
    output word_t      rom_data_o,
    input  word_t      ram_addr_i,
    input  word_t      ram_wdata_i,
    input  logic       ram_we_i,
    input  logic       ram_re_i,
    input  mask_t      ram_mask_i,
    output word_t      ram_rdata_o
);

    // 256 words each, word index from address bits 9:2
    word_t rom [0:255];
    word_t ram [0:255];

    // disabled rom reads as a nop
    assign rom_data_o  = rom_ce_i ? rom[rom_addr_i[9:2]] : '0;

    // x outside a load so that stray use of read data shows up
    assign ram_rdata_o = ram_re_i ? ram[ram_addr_i[9:2]] : 'x;

    always @(posedge clk) begin
        if (ram_we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (ram_mask_i[b]) begin
                    ram[ram_addr_i[9:2]][8*b +: 8] <= ram_wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== tests/cpu_assert.sv ====
`timescale 1ns/1ps

module cpu_assert import isa_pkg::*; (
    input logic       clk,
    input logic       arst_n_i,
    input inst_addr_t rom_addr_i,
    input logic       ram_we_i,
    input logic       ram_re_i,
    input mask_t      ram_mask_i
);

    int fail_count = 0;

    // one memory op per cycle in the mem stage
    we_re_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n_i) !(ram_we_i && ram_re_i)
    ) else begin
        fail_count++;
        $error("ram_we_o and ram_re_o high in the same cycle");
    end

    write_has_mask: assert property (
        @(posedge clk) disable iff (!arst_n_i) ram_we_i |-> (ram_mask_i != '0)
    ) else begin
        fail_count++;
        $error("ram_we_o high with an empty byte mask");
    end

    fetch_aligned: assert property (
        @(posedge clk) disable iff (!arst_n_i) rom_addr_i[1:0] == 2'b00
    ) else begin
        fail_count++;
        $error("rom_addr_o not word aligned");
    end

endmodule

bind cpu cpu_assert i_cpu_assert (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .rom_addr_i (rom_addr_o),
    .ram_we_i   (ram_we_o),
    .ram_re_i   (ram_re_o),
    .ram_mask_i (ram_mask_o)
);

// ==== tests/tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu import isa_pkg::*; ();

    localparam inst_addr_t RESET_PC     = 32'h0000_0080;
    localparam word_t      DONE_ADDR    = 32'h0000_03fc;
    localparam int         RESET_CYCLES = 5;
    localparam int         TEST_CYCLES  = 200;
    localparam int         NUM_TESTS    = 6;
    // every test within its own budget, the rest is margin
    localparam int         MAX_CYCLES   = NUM_TESTS * TEST_CYCLES + 800;

    logic       clk;
    logic       arst_n;
    word_t      rom_data;
    inst_addr_t rom_addr;
    logic       rom_ce;
    word_t      ram_rdata;
    word_t      ram_addr;
    word_t      ram_wdata;
    logic       ram_re;
    logic       ram_we;
    mask_t      ram_mask;

    int         errors = 0;
    int         tests_run = 0;
    int         cycle_cnt = 0;
    word_t      lcg_state;
    word_t      prog [$];

    // port activity seen at the falling edge
    inst_addr_t prev_fetch;
    int         fetch_repeats;
    word_t      wr_addr_q [$];
    mask_t      wr_mask_q [$];

    cpu #(.RESET_PC(RESET_PC)) i_dut (
        .clk        (clk),
        .arst_n_i   (arst_n),
        .rom_data_i (rom_data),
        .rom_addr_o (rom_addr),
        .rom_ce_o   (rom_ce),
        .ram_data_i (ram_rdata),
        .ram_addr_o (ram_addr),
        .ram_data_o (ram_wdata),
        .ram_re_o   (ram_re),
        .ram_we_o   (ram_we),
        .ram_mask_o (ram_mask)
    );

    tb_mem_model i_mem (
        .clk         (clk),
        .rom_addr_i  (rom_addr),
        .rom_ce_i    (rom_ce),
        .rom_data_o  (rom_data),
        .ram_addr_i  (ram_addr),
        .ram_wdata_i (ram_wdata),
        .ram_we_i    (ram_we),
        .ram_re_i    (ram_re),
        .ram_mask_i  (ram_mask),
        .ram_rdata_o (ram_rdata)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("tests run: %0d, errors: %0d, assertion failures: %0d",
                     tests_run, errors, i_dut.i_cpu_assert.fail_count);
            $display("Done: errors found");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (arst_n) begin
            if (rom_ce) begin
                if (rom_addr == prev_fetch) begin
                    fetch_repeats++;
                end
                prev_fetch = rom_addr;
            end
            if (ram_we) begin
                wr_addr_q.push_back(ram_addr);
                wr_mask_q.push_back(ram_mask);
            end
        end
    end

    function automatic word_t encode_rtype(funct_t fn, reg_addr_t rd, reg_addr_t rs,
                                           reg_addr_t rt);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t encode_itype(opcode_t op, reg_addr_t rs, reg_addr_t rt,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // store relative to r0
    function automatic word_t store_inst(opcode_t op, reg_addr_t rt, int byte_addr);
        return encode_itype(op, 5'd0, rt, 16'(byte_addr));
    endfunction

    function automatic word_t ram_fill(int idx);
        return 32'hc0de_0000 | (32'(idx) * 32'h0000_0101);
    endfunction

    function word_t next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic emit(word_t inst);
        prog.push_back(inst);
    endtask

    task automatic report_error(string msg);
        errors++;
        $display("** Error at time %0t: %s", $time, msg);
    endtask

    // reset, load rom and ram, release after RESET_CYCLES cycles
    task automatic start_program();
        int base;
        base = RESET_PC[9:2];
        @(posedge clk);
        #2;
        arst_n = 1'b0;
        for (int i = 0; i < 256; i++) begin
            i_mem.rom[i] = '0;
            i_mem.ram[i] = ram_fill(i);
        end
        foreach (prog[i]) begin
            i_mem.rom[(base + i) % 256] = prog[i];
        end
        prog.delete();
        wr_addr_q.delete();
        wr_mask_q.delete();
        fetch_repeats = 0;
        prev_fetch = '1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (rom_ce || ram_we || ram_re) begin
                report_error("memory enables active during reset");
            end
            @(posedge clk);
        end
        #2;
        arst_n = 1'b1;
    endtask

    task automatic wait_done(string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!(ram_we && ram_addr == DONE_ADDR) && n < TEST_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (n >= TEST_CYCLES) begin
            errors++;
            $display("%s: program did not reach its final store within %0d cycles",
                     name, TEST_CYCLES);
        end
        #1;
    endtask

    // final store to DONE_ADDR marks the end of a program
    task automatic run_program(string name);
        emit(store_inst(OPC_SW, 5'd0, DONE_ADDR));
        start_program();
        wait_done(name);
        tests_run++;
    endtask

    task automatic test_reset();
        start_program();
        @(posedge clk);
        @(negedge clk);
        if (rom_ce !== 1'b1) begin
            report_error("rom_ce_o low at the first edge after reset release");
        end
        for (int k = 0; k < 8; k++) begin
            if (rom_addr !== RESET_PC + 32'(4 * k)) begin
                report_error($sformatf("fetch %0d at %h, expected %h",
                                       k, rom_addr, RESET_PC + 32'(4 * k)));
            end
            @(negedge clk);
        end
        tests_run++;
    endtask

    task automatic test_alu_forwarding();
        word_t exp [1:8];
        exp[1] = 32'h0000_1234;
        exp[2] = {16'h8765, 16'h0000};
        exp[3] = exp[2] + {{16{1'b1}}, 16'hff00};
        exp[4] = exp[3] + exp[1];
        exp[5] = exp[4] - exp[2];
        exp[6] = exp[5] & exp[4];
        exp[7] = exp[6] | exp[3];
        exp[8] = ($signed(exp[7]) < $signed(exp[5])) ? 32'd1 : 32'd0;
        emit(encode_itype(OPC_ORI, 5'd0, 5'd1, 16'h1234));
        emit(encode_itype(OPC_LUI, 5'd0, 5'd2, 16'h8765));
        emit(encode_itype(OPC_ADDIU, 5'd2, 5'd3, 16'hff00));
        emit(encode_rtype(FN_ADDU, 5'd4, 5'd3, 5'd1));
        emit(encode_rtype(FN_SUBU, 5'd5, 5'd4, 5'd2));
        emit(encode_rtype(FN_AND, 5'd6, 5'd5, 5'd4));
        emit(encode_rtype(FN_OR, 5'd7, 5'd6, 5'd3));
        emit(encode_rtype(FN_SLT, 5'd8, 5'd7, 5'd5));
        for (int r = 1; r <= 8; r++) begin
            emit(store_inst(OPC_SW, 5'(r), 4 * (r - 1)));
        end
        run_program("alu_forwarding");
        for (int r = 1; r <= 8; r++) begin
            if (i_mem.ram[r - 1] !== exp[r]) begin
                report_error($sformatf("r%0d stored %h, expected %h",
                                       r, i_mem.ram[r - 1], exp[r]));
            end
        end
    endtask

    task automatic test_load_use();
        word_t exp;
        exp = ram_fill(32) + 32'h0000_0101;
        emit(encode_itype(OPC_ORI, 5'd0, 5'd4, 16'h0101));
        emit(encode_itype(OPC_LW, 5'd0, 5'd1, 16'h0080));
        emit(encode_rtype(FN_ADDU, 5'd3, 5'd1, 5'd4));
        emit(store_inst(OPC_SW, 5'd3, 32'h44));
        run_program("load_use");
        if (i_mem.ram[17] !== exp) begin
            report_error($sformatf("load-use sum %h, expected %h", i_mem.ram[17], exp));
        end
        if (fetch_repeats != 1) begin
            report_error($sformatf("fetch address repeated %0d times, expected 1",
                                   fetch_repeats));
        end
    endtask

    task automatic test_branches();
        word_t     val [1:3];
        opcode_t   op [0:3];
        reg_addr_t src_b [0:3];
        logic      taken;
        int        w;
        word_t     exp;
        val[1] = 32'd5;
        val[2] = 32'd5;
        val[3] = 32'd7;
        op     = '{OPC_BEQ, OPC_BEQ, OPC_BNE, OPC_BNE};
        src_b  = '{5'd2, 5'd3, 5'd3, 5'd2};
        for (int r = 1; r <= 3; r++) begin
            emit(encode_itype(OPC_ORI, 5'd0, 5'(r), 16'(val[r])));
        end
        emit(encode_itype(OPC_ORI, 5'd0, 5'd9, 16'h00ab));
        // branch, delay slot, skipped store, target store
        for (int k = 0; k < 4; k++) begin
            emit(encode_itype(op[k], 5'd1, src_b[k], 16'd2));
            emit(store_inst(OPC_SW, 5'd9, 4 * (16 + 3 * k)));
            emit(store_inst(OPC_SW, 5'd9, 4 * (17 + 3 * k)));
            emit(store_inst(OPC_SW, 5'd9, 4 * (18 + 3 * k)));
        end
        run_program("branches");
        for (int k = 0; k < 4; k++) begin
            taken = (op[k] == OPC_BEQ) ? (val[1] == val[src_b[k]]) : (val[1] != val[src_b[k]]);
            w = 16 + 3 * k;
            if (i_mem.ram[w] !== 32'h0000_00ab) begin
                report_error($sformatf("branch %0d: delay slot word %h", k, i_mem.ram[w]));
            end
            exp = taken ? ram_fill(w + 1) : 32'h0000_00ab;
            if (i_mem.ram[w + 1] !== exp) begin
                report_error($sformatf("branch %0d taken %0b: skipped word %h, expected %h",
                                       k, taken, i_mem.ram[w + 1], exp));
            end
            if (i_mem.ram[w + 2] !== 32'h0000_00ab) begin
                report_error($sformatf("branch %0d: target word %h", k, i_mem.ram[w + 2]));
            end
        end
    endtask

    task automatic test_byte_stores();
        logic [7:0] bytes [0:3];
        word_t      cur;
        mask_t      masks [$];
        cur = 32'h1122_3344;
        emit(encode_itype(OPC_LUI, 5'd0, 5'd1, 16'h1122));
        emit(encode_itype(OPC_ORI, 5'd1, 5'd1, 16'h3344));
        emit(store_inst(OPC_SW, 5'd1, 32'h100));
        // snapshot the word after every byte store
        for (int k = 0; k < 4; k++) begin
            bytes[k] = next_random() >> 8;
            emit(encode_itype(OPC_ORI, 5'd0, 5'd2, {8'hee, bytes[k]}));
            emit(store_inst(OPC_SB, 5'd2, 32'h100 + k));
            emit(encode_itype(OPC_LW, 5'd0, 5'd5, 16'h0100));
            emit(store_inst(OPC_SW, 5'd5, 32'h110 + 4 * k));
        end
        run_program("byte_stores");
        for (int k = 0; k < 4; k++) begin
            cur[8*k +: 8] = bytes[k];
            if (i_mem.ram[68 + k] !== cur) begin
                report_error($sformatf("word after byte store %0d is %h, expected %h",
                                       k, i_mem.ram[68 + k], cur));
            end
        end
        if (i_mem.ram[64] !== cur) begin
            report_error($sformatf("merged word %h, expected %h", i_mem.ram[64], cur));
        end
        foreach (wr_addr_q[i]) begin
            if (wr_addr_q[i] == 32'h100) begin
                masks.push_back(wr_mask_q[i]);
            end
        end
        if (masks.size() != 5) begin
            report_error($sformatf("%0d writes to the merged word, expected 5", masks.size()));
        end else begin
            for (int k = 0; k < 4; k++) begin
                if (masks[k + 1] !== 4'b0001 << k) begin
                    report_error($sformatf("byte store %0d mask %b", k, masks[k + 1]));
                end
            end
        end
    endtask

    task automatic test_random_arith();
        word_t a [0:19];
        word_t b [0:19];
        for (int i = 0; i < 20; i++) begin
            a[i] = next_random();
            b[i] = next_random();
            emit(encode_itype(OPC_LUI, 5'd0, 5'd1, a[i][31:16]));
            emit(encode_itype(OPC_ORI, 5'd1, 5'd1, a[i][15:0]));
            emit(encode_itype(OPC_LUI, 5'd0, 5'd2, b[i][31:16]));
            emit(encode_itype(OPC_ORI, 5'd2, 5'd2, b[i][15:0]));
            emit(encode_rtype(FN_ADDU, 5'd3, 5'd1, 5'd2));
            emit(encode_rtype(FN_SUBU, 5'd4, 5'd1, 5'd2));
            emit(store_inst(OPC_SW, 5'd3, 8 * i));
            emit(store_inst(OPC_SW, 5'd4, 8 * i + 4));
        end
        run_program("random_arith");
        for (int i = 0; i < 20; i++) begin
            if (i_mem.ram[2 * i] !== a[i] + b[i]) begin
                report_error($sformatf("pair %0d: sum %h, expected %h",
                                       i, i_mem.ram[2 * i], a[i] + b[i]));
            end
            if (i_mem.ram[2 * i + 1] !== a[i] - b[i]) begin
                report_error($sformatf("pair %0d: difference %h, expected %h",
                                       i, i_mem.ram[2 * i + 1], a[i] - b[i]));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        arst_n = 1'b0;
        lcg_state = 32'd41278;
        test_reset();
        test_alu_forwarding();
        test_load_use();
        test_branches();
        test_byte_stores();
        test_random_arith();
        $display("tests run: %0d, errors: %0d, assertion failures: %0d",
                 tests_run, errors, i_dut.i_cpu_assert.fail_count);
        if (errors == 0 && i_dut.i_cpu_assert.fail_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== mini_mips.f ====
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/stage_reg.sv
verilog/fetch_unit.sv
verilog/regfile.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/mem_unit.sv
verilog/cpu.sv
tests/tb_mem_model.sv
tests/cpu_assert.sv
tests/tb_cpu.sv
